/* Bender.yml */
package:
  name: pkt_load

sources:
  - bpf_defs_pkg.sv
  - wb_regs_pkg.sv
  - pkt_mem.sv
  - load_align.sv
  - pkt_len_counter.sv
  - cmd_fsm.sv
  - pkt_load_top.sv
  - target: test
    files:
      - pkt_load_sva.sv
      - tb_pkt_load_top.sv

/* bpf_defs_pkg.sv */
package bpf_defs_pkg;

    // Load sizes, same field values as the classic BPF size bits
    typedef enum logic [1:0] {
        BPF_W = 2'd0,
        BPF_H = 2'd1,
        BPF_B = 2'd2
    } xfer_sz_e;

    // All-zero command word does nothing
    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_STORE = 2'd1,
        OP_LOAD  = 2'd2
    } cmd_op_e;

    // Load command as written to CMD
    typedef struct packed {
        cmd_op_e     op;
        xfer_sz_e    sz;
        logic [11:0] rsvd;
        logic [15:0] addr;
    } ld_cmd_t;

    // Store command, op field sits at the same place
    typedef struct packed {
        cmd_op_e     op;
        logic [5:0]  rsvd;
        logic [7:0]  data;
        logic [15:0] addr;
    } st_cmd_t;

    // One CMD word, read as load or store depending on op
    typedef union packed {
        ld_cmd_t ld;
        st_cmd_t st;
    } cmd_word_u;

    // STATUS layout
    localparam int STAT_LEN_W    = 16;
    localparam int STAT_OOB_BIT  = 16;
    localparam int STAT_BUSY_BIT = 17;

    // Number of bytes moved by one load
    function automatic logic [2:0] xfer_bytes(xfer_sz_e sz);
        case (sz)
            BPF_H:   return 3'd2;
            BPF_B:   return 3'd1;
            default: return 3'd4;
        endcase
    endfunction

endpackage

/* cmd_fsm.sv */
module cmd_fsm
    import bpf_defs_pkg::*, wb_regs_pkg::*;
#(
    parameter int BYTE_ADDR_WIDTH = 12,
    parameter int ADDR_WIDTH      = 9,
    parameter int WORD_W          = 64
) (
    input  logic                       clk,
    input  logic                       rst,

    // Wishbone classic slave
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  logic [WB_ADR_W-1:0]        wb_adr_i,
    input  logic [31:0]                wb_dat_i,
    output logic [31:0]                wb_dat_o,
    output logic                       wb_ack_o,

    input  logic [BYTE_ADDR_WIDTH:0]   pkt_len_i,

    // Store port of pkt_mem
    output logic                       wr_en_o,
    output logic [ADDR_WIDTH-1:0]      wr_addr_o,
    output logic [WORD_W/8-1:0]        wr_be_o,
    output logic [WORD_W-1:0]          wr_data_o,

    // Length counter
    output logic                       st_en_o,
    output logic [BYTE_ADDR_WIDTH-1:0] st_byte_addr_o,
    output logic                       clr_o,

    // Load path
    output logic                       ld_en_o,
    output logic [BYTE_ADDR_WIDTH-1:0] ld_byte_addr_o,
    output xfer_sz_e                   ld_sz_o,
    input  logic [31:0]                ld_data_i,
    input  logic                       ld_vld_i
);

    localparam int OFF_W     = BYTE_ADDR_WIDTH - ADDR_WIDTH;
    localparam int NB        = WORD_W / 8;
    localparam int PKT_BYTES = 2 ** BYTE_ADDR_WIDTH;

    typedef enum logic [1:0] {
        IDLE,
        DECODE,
        LOAD_WAIT,
        ACK
    } state_e;

    state_e           state_q;
    cmd_word_u        cmd;
    logic             in_decode;
    logic             cmd_wr;
    logic             is_load;
    logic             is_store;
    logic             st_ok;
    logic             ld_oob;
    logic [OFF_W-1:0] st_off;
    logic [16:0]      ld_end;
    logic [16:0]      ld_lane_end;
    logic [31:0]      status_word;
    logic [31:0]      result_q;
    logic             oob_q;
    logic [31:0]      dat_q;

    // Master holds its inputs until ack, so DECODE reads them directly
    assign cmd       = wb_dat_i;
    assign in_decode = (state_q == DECODE);
    assign cmd_wr    = in_decode && wb_we_i && (wb_adr_i == REG_CMD);
    assign is_load   = cmd_wr && (cmd.ld.op == OP_LOAD);
    assign is_store  = cmd_wr && (cmd.st.op == OP_STORE);

    // Stores beyond the RAM are dropped
    assign st_ok  = ({1'b0, cmd.st.addr} < 17'(PKT_BYTES));
    assign st_off = cmd.st.addr[OFF_W-1:0];

    // Bounds: end past packet length, or bytes spilling into the next word
    assign ld_end      = {1'b0, cmd.ld.addr} + 17'(xfer_bytes(cmd.ld.sz));
    assign ld_lane_end = 17'(cmd.ld.addr[OFF_W-1:0]) + 17'(xfer_bytes(cmd.ld.sz));
    assign ld_oob      = (ld_end > 17'(pkt_len_i)) || (ld_lane_end > 17'(NB));

    // Store goes straight to memory and counter in DECODE
    assign wr_en_o        = is_store && st_ok;
    assign wr_addr_o      = cmd.st.addr[BYTE_ADDR_WIDTH-1:OFF_W];
    assign wr_data_o      = {NB{cmd.st.data}};
    assign st_en_o        = wr_en_o;
    assign st_byte_addr_o = cmd.st.addr[BYTE_ADDR_WIDTH-1:0];

    // Byte 0 sits in the top lane
    always_comb begin
        wr_be_o = '0;
        wr_be_o[NB - 1 - st_off] = 1'b1;
    end

    assign clr_o = in_decode && wb_we_i && (wb_adr_i == REG_CTRL)
                   && wb_dat_i[CTRL_CLR_BIT];

    // Only loads that pass the check reach the pipeline
    assign ld_en_o        = is_load && !ld_oob;
    assign ld_byte_addr_o = cmd.ld.addr[BYTE_ADDR_WIDTH-1:0];
    assign ld_sz_o        = cmd.ld.sz;

    always_comb begin
        status_word = '0;
        status_word[STAT_LEN_W-1:0] = STAT_LEN_W'(pkt_len_i);
        status_word[STAT_OOB_BIT]   = oob_q;
        status_word[STAT_BUSY_BIT]  = (state_q == LOAD_WAIT);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q  <= IDLE;
            result_q <= '0;
            oob_q    <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (wb_cyc_i && wb_stb_i) begin
                        state_q <= DECODE;
                    end
                end
                DECODE: begin
                    if (ld_en_o) begin
                        state_q <= LOAD_WAIT;
                    end else begin
                        state_q <= ACK;
                        // Rejected load reads as zero
                        if (is_load) begin
                            result_q <= '0;
                            oob_q    <= 1'b1;
                        end
                    end
                end
                LOAD_WAIT: begin
                    // One load in flight, vld comes back 1+PESS later
                    if (ld_vld_i) begin
                        result_q <= ld_data_i;
                        oob_q    <= 1'b0;
                        state_q  <= ACK;
                    end
                end
                ACK: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Read data latched in DECODE, shown during ACK
    always_ff @(posedge clk) begin
        if (in_decode && !wb_we_i) begin
            case (wb_adr_i)
                REG_RESULT: dat_q <= result_q;
                REG_STATUS: dat_q <= status_word;
                default:    dat_q <= '0;
            endcase
        end
    end

    assign wb_dat_o = dat_q;
    // Single-cycle ack, ACK always returns to IDLE
    assign wb_ack_o = (state_q == ACK);

endmodule

/* filelist.f */
bpf_defs_pkg.sv
wb_regs_pkg.sv
pkt_mem.sv
load_align.sv
pkt_len_counter.sv
cmd_fsm.sv
pkt_load_top.sv
pkt_load_sva.sv
tb_pkt_load_top.sv

/* load_align.sv */
module load_align
    import bpf_defs_pkg::*;
#(
    parameter int BYTE_ADDR_WIDTH = 12,
    parameter int ADDR_WIDTH      = 9,
    parameter int WORD_W          = 64,
    parameter int PESS            = 0
) (
    input  logic                       clk,
    input  logic                       rst,

    // Load request from the FSM
    input  logic                       ld_en_i,
    input  logic [BYTE_ADDR_WIDTH-1:0] ld_byte_addr_i,
    input  xfer_sz_e                   ld_sz_i,

    // Memory read port
    output logic                       rd_en_o,
    output logic [ADDR_WIDTH-1:0]      rd_addr_o,
    input  logic [WORD_W-1:0]          rd_word_i,

    // Aligned result, 1+PESS cycles after ld_en_i
    output logic [31:0]                ld_data_o,
    output logic                       ld_vld_o
);

    localparam int OFF_W   = BYTE_ADDR_WIDTH - ADDR_WIDTH;
    // Fixed read latency of pkt_mem
    localparam int MEM_LAT = 1;

    logic [OFF_W-1:0]   off_pipe [MEM_LAT];
    xfer_sz_e           sz_pipe  [MEM_LAT];
    logic [MEM_LAT-1:0] vld_pipe;
    logic [OFF_W+2:0]   bit_off;
    logic [WORD_W+31:0] word_ext;
    logic [31:0]        sel_bytes;
    logic [31:0]        fit_data;

    // Upper bits pick the word, lower bits the byte inside it
    assign rd_en_o   = ld_en_i;
    assign rd_addr_o = ld_byte_addr_i[BYTE_ADDR_WIDTH-1:OFF_W];

    // Offset and size wait for the memory
    always_ff @(posedge clk) begin
        off_pipe[0] <= ld_byte_addr_i[OFF_W-1:0];
        sz_pipe[0]  <= ld_sz_i;
        for (int i = 1; i < MEM_LAT; i++) begin
            off_pipe[i] <= off_pipe[i-1];
            sz_pipe[i]  <= sz_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= ld_en_i;
            for (int i = 1; i < MEM_LAT; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    // Zero bytes appended so a read past the word end sees zeros
    assign word_ext  = {rd_word_i, 32'd0};
    assign bit_off   = {off_pipe[MEM_LAT-1], 3'b000};
    // 32 bits starting at the byte offset, byte 0 at the top
    assign sel_bytes = word_ext[WORD_W + 31 - bit_off -: 32];

    // Keep the leading bytes, right-justify, pad left with zeros
    always_comb begin
        case (sz_pipe[MEM_LAT-1])
            BPF_W:   fit_data = sel_bytes;
            BPF_H:   fit_data = {16'd0, sel_bytes[31:16]};
            BPF_B:   fit_data = {24'd0, sel_bytes[31:24]};
            default: fit_data = '0;
        endcase
    end

    generate
        if (PESS != 0) begin : g_out_reg
            // Extra stage to break the select path
            always_ff @(posedge clk) begin
                if (!rst) begin
                    ld_data_o <= '0;
                    ld_vld_o  <= 1'b0;
                end else begin
                    ld_data_o <= fit_data;
                    ld_vld_o  <= vld_pipe[MEM_LAT-1];
                end
            end
        end else begin : g_out_comb
            assign ld_data_o = fit_data;
            assign ld_vld_o  = vld_pipe[MEM_LAT-1];
        end
    endgenerate

endmodule

/* pkt_len_counter.sv */
module pkt_len_counter #(
    parameter int BYTE_ADDR_WIDTH = 12
) (
    input  logic                       clk,
    input  logic                       rst,

    // Store seen by the memory
    input  logic                       st_en_i,
    input  logic [BYTE_ADDR_WIDTH-1:0] st_byte_addr_i,

    // Start a new packet
    input  logic                       clr_i,

    // One bit wider so a full RAM fits
    output logic [BYTE_ADDR_WIDTH:0]   pkt_len_o
);

    logic [BYTE_ADDR_WIDTH:0] st_end;

    // Length implied by this store
    assign st_end = {1'b0, st_byte_addr_i} + 1'b1;

    // Only grows, so stores out of order still give the highest end
    always_ff @(posedge clk) begin
        if (!rst) begin
            pkt_len_o <= '0;
        end else if (clr_i) begin
            // Clear wins over a store in the same cycle
            pkt_len_o <= '0;
        end else if (st_en_i && (st_end > pkt_len_o)) begin
            pkt_len_o <= st_end;
        end
    end

endmodule

/* pkt_load_sva.sv */
module pkt_load_sva #(
    parameter int PESS = 0
) (
    input logic clk,
    input logic rst,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,
    input logic ld_en_i,
    input logic ld_vld_i
);

    // Ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst)
        ack_i |=> !ack_i)
        else $error("wb_ack_o held longer than one cycle");

    // Ack only answers a strobe, master drops stb at the ack edge
    ack_needs_stb: assert property (@(posedge clk) disable iff (!rst)
        ack_i |-> $past(cyc_i && stb_i))
        else $error("wb_ack_o without a strobe");

    // Fixed load latency
    vld_latency: assert property (@(posedge clk) disable iff (!rst)
        ld_en_i |-> ##(1 + PESS) ld_vld_i)
        else $error("ld_vld did not follow ld_en after 1+PESS cycles");

endmodule

// Load pipeline side, bus inputs tied off
bind load_align pkt_load_sva #(.PESS(PESS)) load_align_sva_i (
    .clk      (clk),
    .rst      (rst),
    .cyc_i    (1'b0),
    .stb_i    (1'b0),
    .ack_i    (1'b0),
    .ld_en_i  (ld_en_i),
    .ld_vld_i (ld_vld_o)
);

// Wishbone side, load inputs tied off
bind cmd_fsm pkt_load_sva #(.PESS(0)) cmd_fsm_sva_i (
    .clk      (clk),
    .rst      (rst),
    .cyc_i    (wb_cyc_i),
    .stb_i    (wb_stb_i),
    .ack_i    (wb_ack_o),
    .ld_en_i  (1'b0),
    .ld_vld_i (1'b0)
);

/* pkt_load_top.sv */
module pkt_load_top
    import bpf_defs_pkg::*, wb_regs_pkg::*;
#(
    parameter int BYTE_ADDR_WIDTH = 12,
    parameter int ADDR_WIDTH      = 9,
    parameter int PESS            = 0
) (
    input  logic                clk,
    input  logic                rst,

    // Host port
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [WB_ADR_W-1:0] wb_adr_i,
    input  logic [31:0]         wb_dat_i,
    output logic [31:0]         wb_dat_o,
    output logic                wb_ack_o
);

    // Bytes per RAM word follow from the two address widths
    localparam int WORD_W = 8 * (2 ** (BYTE_ADDR_WIDTH - ADDR_WIDTH));

    logic [BYTE_ADDR_WIDTH:0]   pkt_len;
    logic                       wr_en;
    logic [ADDR_WIDTH-1:0]      wr_addr;
    logic [WORD_W/8-1:0]        wr_be;
    logic [WORD_W-1:0]          wr_data;
    logic                       st_en;
    logic [BYTE_ADDR_WIDTH-1:0] st_byte_addr;
    logic                       clr;
    logic                       ld_en;
    logic [BYTE_ADDR_WIDTH-1:0] ld_byte_addr;
    xfer_sz_e                   ld_sz;
    logic [31:0]                ld_data;
    logic                       ld_vld;
    logic                       rd_en;
    logic [ADDR_WIDTH-1:0]      rd_addr;
    logic [WORD_W-1:0]          rd_word;

    cmd_fsm #(
        .BYTE_ADDR_WIDTH (BYTE_ADDR_WIDTH),
        .ADDR_WIDTH      (ADDR_WIDTH),
        .WORD_W          (WORD_W)
    ) cmd_fsm_i (
        .clk            (clk),
        .rst            (rst),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .pkt_len_i      (pkt_len),
        .wr_en_o        (wr_en),
        .wr_addr_o      (wr_addr),
        .wr_be_o        (wr_be),
        .wr_data_o      (wr_data),
        .st_en_o        (st_en),
        .st_byte_addr_o (st_byte_addr),
        .clr_o          (clr),
        .ld_en_o        (ld_en),
        .ld_byte_addr_o (ld_byte_addr),
        .ld_sz_o        (ld_sz),
        .ld_data_i      (ld_data),
        .ld_vld_i       (ld_vld)
    );

    pkt_len_counter #(
        .BYTE_ADDR_WIDTH (BYTE_ADDR_WIDTH)
    ) pkt_len_counter_i (
        .clk            (clk),
        .rst            (rst),
        .st_en_i        (st_en),
        .st_byte_addr_i (st_byte_addr),
        .clr_i          (clr),
        .pkt_len_o      (pkt_len)
    );

    load_align #(
        .BYTE_ADDR_WIDTH (BYTE_ADDR_WIDTH),
        .ADDR_WIDTH      (ADDR_WIDTH),
        .WORD_W          (WORD_W),
        .PESS            (PESS)
    ) load_align_i (
        .clk            (clk),
        .rst            (rst),
        .ld_en_i        (ld_en),
        .ld_byte_addr_i (ld_byte_addr),
        .ld_sz_i        (ld_sz),
        .rd_en_o        (rd_en),
        .rd_addr_o      (rd_addr),
        .rd_word_i      (rd_word),
        .ld_data_o      (ld_data),
        .ld_vld_o       (ld_vld)
    );

    pkt_mem #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .WORD_W     (WORD_W)
    ) pkt_mem_i (
        .clk       (clk),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_be_i   (wr_be),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_word_o (rd_word)
    );

endmodule

/* pkt_mem.sv */
module pkt_mem #(
    parameter int ADDR_WIDTH = 9,
    parameter int WORD_W     = 64
) (
    input  logic                  clk,

    // Store side, one byte lane at a time
    input  logic                  wr_en_i,
    input  logic [ADDR_WIDTH-1:0] wr_addr_i,
    input  logic [WORD_W/8-1:0]   wr_be_i,
    input  logic [WORD_W-1:0]     wr_data_i,

    // Load side
    input  logic                  rd_en_i,
    input  logic [ADDR_WIDTH-1:0] rd_addr_i,
    output logic [WORD_W-1:0]     rd_word_o
);

    localparam int NB    = WORD_W / 8;
    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // Big-endian words, byte 0 lives in lane NB-1
    logic [WORD_W-1:0] mem [DEPTH];

    // Lane-masked write
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int i = 0; i < NB; i++) begin
                if (wr_be_i[i]) begin
                    mem[wr_addr_i][8*i +: 8] <= wr_data_i[8*i +: 8];
                end
            end
        end
    end

    // Registered read
    // data comes out one cycle after rd_en_i
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_word_o <= mem[rd_addr_i];
        end
    end

endmodule

/* tb_pkt_load_top.sv */
module tb_pkt_load_top
    import bpf_defs_pkg::*, wb_regs_pkg::*;
();

    localparam int BAW        = 12;
    localparam int AW         = 9;
    localparam int WORD_BYTES = 2 ** (BAW - AW);
    localparam int ACK_TMO    = 50;

    typedef enum {K_DATA, K_SZ, K_STATUS} chk_kind_e;

    // One pending comparison
    typedef struct {
        chk_kind_e   kind;
        string       name;
        xfer_sz_e    sz;
        logic [31:0] exp;
        logic [31:0] act;
    } chk_t;

    logic                clk;
    logic                rst;
    logic                wb_cyc_i;
    logic                wb_stb_i;
    logic                wb_we_i;
    logic [WB_ADR_W-1:0] wb_adr_i;
    logic [31:0]         wb_dat_i;
    logic [31:0]         wb_dat_o;
    logic                wb_ack_o;

    // Host-side model of the packet
    logic [7:0] pkt_bytes [2**BAW];
    int         mdl_len;
    bit         mdl_oob;
    chk_t       chk_q [$];
    int         n_tests;
    int         n_errors;
    integer     seed;

    pkt_load_top #(
        .BYTE_ADDR_WIDTH (BAW),
        .ADDR_WIDTH      (AW),
        .PESS            (1)
    ) pkt_load_top_i (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Expected load value, big-endian and right-justified
    function automatic logic [31:0] ref_load(input int addr, input xfer_sz_e sz,
                                             output bit oob);
        int          n;
        logic [31:0] v;
        case (sz)
            BPF_B:   n = 1;
            BPF_H:   n = 2;
            default: n = 4;
        endcase
        // Past the packet end, or spilling into the next RAM word
        oob = ((addr + n) > mdl_len) || (((addr % WORD_BYTES) + n) > WORD_BYTES);
        v = '0;
        if (!oob) begin
            for (int i = 0; i < n; i++) begin
                v = {v[23:0], pkt_bytes[addr + i]};
            end
        end
        return v;
    endfunction

    task automatic check_data(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        n_tests++;
        if (act !== exp) begin
            n_errors++;
            $display("FAIL %s expected %08h actual %08h", name, exp, act);
        end else begin
            $display("PASS %s", name);
        end
    endtask

    task automatic check_sz_result(input string name, input xfer_sz_e sz,
                                   input logic [31:0] exp, input logic [31:0] act);
        n_tests++;
        // Full word compare, so the zero padding is checked too
        if (act !== exp) begin
            n_errors++;
            $display("FAIL %s (%s) expected %08h actual %08h", name, sz.name(), exp, act);
        end else begin
            $display("PASS %s (%s)", name, sz.name());
        end
    endtask

    task automatic check_status(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        n_tests++;
        // Whole word, bits above OOB read as zero between accesses
        if (act !== exp) begin
            n_errors++;
            $display("FAIL %s expected %08h actual %08h", name, exp, act);
        end else begin
            $display("PASS %s", name);
        end
    endtask

    // Compare process, drains queued results
    initial begin
        chk_t c;
        forever begin
            @(posedge clk);
            while (chk_q.size() > 0) begin
                c = chk_q.pop_front();
                case (c.kind)
                    K_DATA:  check_data(c.name, c.exp, c.act);
                    K_SZ:    check_sz_result(c.name, c.sz, c.exp, c.act);
                    default: check_status(c.name, c.exp, c.act);
                endcase
            end
        end
    end

    // One classic cycle, held until ack
    task automatic wb_access(input bit we, input logic [WB_ADR_W-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int cnt;
        bit got;
        @(negedge clk);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        cnt = 0;
        got = 1'b0;
        rdata = '0;
        while (!got && (cnt < ACK_TMO)) begin
            @(negedge clk);
            if (wb_ack_o) begin
                got = 1'b1;
                rdata = wb_dat_o;
            end else begin
                cnt++;
            end
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        if (!got) begin
            n_errors++;
            $display("ERROR: no acknowledge from the DUT on register %0d", adr);
        end
    endtask

    task automatic store_byte(input int addr, input logic [7:0] data);
        cmd_word_u   cmd;
        logic [31:0] unused;
        cmd = '0;
        cmd.st.op   = OP_STORE;
        cmd.st.data = data;
        cmd.st.addr = addr[15:0];
        wb_access(1'b1, REG_CMD, cmd, unused);
        pkt_bytes[addr] = data;
        if (addr + 1 > mdl_len) begin
            mdl_len = addr + 1;
        end
    endtask

    task automatic load_check(input string name, input int addr, input xfer_sz_e sz);
        cmd_word_u   cmd;
        logic [31:0] act;
        logic [31:0] exp;
        chk_t        c;
        cmd = '0;
        cmd.ld.op   = OP_LOAD;
        cmd.ld.sz   = sz;
        cmd.ld.addr = addr[15:0];
        wb_access(1'b1, REG_CMD, cmd, act);
        wb_access(1'b0, REG_RESULT, '0, act);
        exp = ref_load(addr, sz, mdl_oob);
        c = '{K_SZ, $sformatf("%s@%0d", name, addr), sz, exp, act};
        chk_q.push_back(c);
    endtask

    task automatic status_check(input string name);
        logic [31:0] act;
        logic [31:0] exp;
        chk_t        c;
        wb_access(1'b0, REG_STATUS, '0, act);
        exp = '0;
        exp[15:0] = mdl_len[15:0];
        exp[STAT_OOB_BIT] = mdl_oob;
        c = '{K_STATUS, name, BPF_W, exp, act};
        chk_q.push_back(c);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] act;
        int          tmo;
        chk_t        c;
        seed     = 71;
        rst      = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        mdl_len  = 0;
        mdl_oob  = 1'b0;
        n_tests  = 0;
        n_errors = 0;
        repeat (5) @(negedge clk);
        rst = 1'b1;

        // Reset state
        status_check("reset_status");
        wb_access(1'b0, REG_RESULT, '0, act);
        c = '{K_DATA, "reset_result", BPF_W, 32'd0, act};
        chk_q.push_back(c);

        // Fill 64 bytes, then random byte loads
        for (int a = 0; a < 64; a++) begin
            r = $random(seed);
            store_byte(a, r[7:0]);
        end
        status_check("len_after_fill");
        for (int i = 0; i < 12; i++) begin
            r = $random(seed);
            load_check("byte_ld", int'(r[5:0]), BPF_B);
        end

        // Aligned halfwords and words
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            load_check("half_ld", int'({r[5:1], 1'b0}), BPF_H);
            r = $random(seed);
            load_check("word_ld", int'({r[5:2], 2'b00}), BPF_W);
        end

        // Past packet end inside one word, then word crossings
        load_check("oob_len", 64, BPF_W);
        status_check("oob_len_flag");
        load_check("oob_cross_h", 7, BPF_H);
        load_check("oob_cross_w", 13, BPF_W);
        status_check("oob_cross_flag");
        load_check("valid_after_oob", 8, BPF_W);
        status_check("oob_cleared");

        // Length clear, then a store far up
        wb_access(1'b1, REG_CTRL, 32'd1, act);
        mdl_len = 0;
        status_check("len_cleared");
        load_check("oob_after_clr", 0, BPF_B);
        r = $random(seed);
        store_byte(1000, r[7:0]);
        status_check("len_high_store");
        load_check("high_byte_ld", 1000, BPF_B);
        load_check("old_word_ld", 4, BPF_W);

        // Let the compare process catch up
        tmo = 0;
        while ((chk_q.size() > 0) && (tmo < 100)) begin
            @(posedge clk);
            tmo++;
        end
        if (chk_q.size() > 0) begin
            n_errors++;
            $display("ERROR: compare process did not drain its queue");
        end
        @(negedge clk);
        $display("Tests run %0d, errors %0d", n_tests, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* wb_regs_pkg.sv */
package wb_regs_pkg;

    // Host sees four 32-bit registers
    localparam int WB_ADR_W = 2;

    // Word offsets on wb_adr_i
    // CMD, write only
    localparam logic [WB_ADR_W-1:0] REG_CMD    = 2'd0;
    // RESULT, read only, last load value
    localparam logic [WB_ADR_W-1:0] REG_RESULT = 2'd1;
    // STATUS, read only, length and flags
    localparam logic [WB_ADR_W-1:0] REG_STATUS = 2'd2;
    // CTRL, write only
    localparam logic [WB_ADR_W-1:0] REG_CTRL   = 2'd3;

    // CTRL bit that clears the packet length
    localparam int CTRL_CLR_BIT = 0;

endpackage
